// ==== logic/mioc_pkg.sv ====
// field widths, address and map types, map select codes, map port decode and the enums
package mioc_pkg;

   localparam int ADDR_HI_W = 3;                   // ba15..ba13
   localparam int MAP_W     = 4;                   // map register / bd nibble
   localparam int SEL_W     = 2;                   // one half's select field

   typedef logic [ADDR_HI_W-1:0] addr_hi_t;        // [2] = ba15, [1] = ba14, [0] = ba13
   typedef logic [MAP_W-1:0]     map_reg_t;        // [1:0] lower half, [3:2] upper half
   typedef logic [SEL_W-1:0]     bank_sel_t;       // select code of the addressed half

   // lower half (0000-7fff) select codes, map bits 1..0
   localparam bank_sel_t LOWER_BOOT_ROM = 2'd0;    // boot rom in the first 8k only
   localparam bank_sel_t LOWER_RAM      = 2'd1;    // dram on the cas1 bank
   localparam bank_sel_t LOWER_AUX_ROM  = 2'd2;    // expansion rom slot
   localparam bank_sel_t LOWER_EN245    = 2'd3;    // onboard 245 buffer

   // upper half (8000-ffff) select codes, map bits 3..2
   localparam bank_sel_t UPPER_RAM     = 2'd0;     // dram on the cas2 bank
   localparam bank_sel_t UPPER_AUX_ROM = 2'd1;     // expansion rom slot
   localparam bank_sel_t UPPER_EN245   = 2'd2;     // onboard 245 buffer
   localparam bank_sel_t UPPER_NONE    = 2'd3;     // nothing selected

   // i/o port that holds the memory map, decoded from ba7 and ba6
   localparam logic MAP_PORT_BA7 = 1'b1;           // ba7 level of the map port
   localparam logic MAP_PORT_BA6 = 1'b0;           // ba6 level of the map port

   // memory target of the current address
   typedef enum logic [2:0] {
      TGT_NONE      = 3'd0,                        // no device so only ras and mux strobe
      TGT_BOOT_ROM  = 3'd1,                        // boot_rom_cs_n
      TGT_RAM_LOWER = 3'd2,                        // cas1_n
      TGT_RAM_UPPER = 3'd3,                        // cas2_n
      TGT_AUX_ROM   = 3'd4,                        // aux_rom_cs_n
      TGT_EN245     = 3'd5                         // en245_n
   } target_e;

   // dram strobe sequencer states
   typedef enum logic [2:0] {
      ST_IDLE    = 3'd0,                           // waiting for mreq_n
      ST_ROW     = 3'd1,                           // row strobe and selects
      ST_MUXED   = 3'd2,                           // address mux switched to column
      ST_COLUMN  = 3'd3,                           // column strobe active
      ST_REFRESH = 3'd4                            // ras-only refresh
   } dram_state_e;

endpackage

// ==== logic/io_map_register.sv ====
// map port write decode and the 4-bit memory-map register
module io_map_register
   import mioc_pkg::*;
(
   input  logic     b_phi,                         // z80 clock
   input  logic     reset,                         // sync, active high
   input  logic     ba7,                           // address line 7
   input  logic     ba6,                           // address line 6
   input  map_reg_t bd,                            // data lines bd3..bd0
   input  logic     iorq_n,                        // z80 i/o request
   input  logic     bwr_n,                         // buffered write
   output map_reg_t map                            // current memory map
);

   logic port_hit;                                 // address matches the map port
   logic map_wr;                                   // qualified i/o write to the port

   // partial port decode on ba7 and ba6 alone
   assign port_hit = (ba7 == MAP_PORT_BA7) && (ba6 == MAP_PORT_BA6);
   assign map_wr   = port_hit && !iorq_n && !bwr_n; // i/o cycle with write strobe

   always_ff @(posedge b_phi) begin
      if (reset) begin
         map <= '0;                                // boot rom low, ram high
      end else if (map_wr) begin
         map <= bd;                                // visible on the next cycle
      end
   end

endmodule

// ==== logic/memory_decoder.sv ====
// half select from ba15 and decode of the map code to a memory target
module memory_decoder
   import mioc_pkg::*;
(
   input  addr_hi_t ba,                            // ba15..ba13
   input  map_reg_t map,                           // memory-map register
   output target_e  target                         // decoded memory target
);

   logic      upper_half;                          // ba15 set
   logic      boot_window;                         // ba14 and ba13 both clear
   bank_sel_t sel;                                 // select field of the addressed half

   assign upper_half  = ba[2];
   assign boot_window = (ba[1:0] == 2'b00);        // boot rom only decodes 0000-1fff
   assign sel         = upper_half ? map[3:2] : map[1:0];

   always_comb begin
      target = TGT_NONE;                           // nothing selected by default
      if (upper_half) begin
         case (sel)
            UPPER_RAM:     target = TGT_RAM_UPPER;
            UPPER_AUX_ROM: target = TGT_AUX_ROM;
            UPPER_EN245:   target = TGT_EN245;
            UPPER_NONE:    target = TGT_NONE;      // open space
            default:       target = TGT_NONE;
         endcase
      end else begin
         case (sel)
            LOWER_BOOT_ROM: begin
               if (boot_window) begin
                  target = TGT_BOOT_ROM;
               end else begin
                  target = TGT_NONE;               // rest of the lower half unmapped
               end
            end
            LOWER_RAM:     target = TGT_RAM_LOWER;
            LOWER_AUX_ROM: target = TGT_AUX_ROM;
            LOWER_EN245:   target = TGT_EN245;
            default:       target = TGT_NONE;
         endcase
      end
   end

endmodule

// ==== logic/dram_sequencer.sv ====
// access and refresh FSM with registered dram strobes and chip selects
module dram_sequencer
   import mioc_pkg::*;
(
   input  logic    b_phi,                          // z80 clock
   input  logic    reset,                          // sync, active high
   input  logic    mreq_n,                         // memory request
   input  logic    rfsh_n,                         // refresh cycle marker
   input  target_e target,                         // decoded target, sampled at start
   output logic    ras_n,                          // row address strobe
   output logic    mux,                            // address mux, high = column
   output logic    cas1_n,                         // column strobe for lower ram
   output logic    cas2_n,                         // column strobe for upper ram
   output logic    boot_rom_cs_n,                  // boot rom select
   output logic    aux_rom_cs_n,                   // expansion rom select
   output logic    en245_n                         // onboard 245 enable
);

   dram_state_e state, state_nxt;                  // access state
   target_e     tgt_q;                             // target held for the whole access
   logic        access;                            // row, muxed or column state
   logic        ras_d, mux_d, cas1_d, cas2_d;      // active-high strobe terms
   logic        boot_d, aux_d, en245_d;            // active-high select terms

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (!mreq_n) begin
               state_nxt = !rfsh_n ? ST_REFRESH : ST_ROW;
            end
         end
         ST_ROW:     state_nxt = mreq_n ? ST_IDLE : ST_MUXED;
         ST_MUXED:   state_nxt = mreq_n ? ST_IDLE : ST_COLUMN;
         ST_COLUMN:  state_nxt = mreq_n ? ST_IDLE : ST_COLUMN;  // held by long mreq_n
         ST_REFRESH: state_nxt = mreq_n ? ST_IDLE : ST_REFRESH;
         default:    state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge b_phi) begin
      if (reset) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // target captured on the start edge of a normal access
   always_ff @(posedge b_phi) begin
      if (state == ST_IDLE && !mreq_n && rfsh_n) begin
         tgt_q <= target;
      end
   end

   // strobe terms decoded from the present state and registered below for one cycle delay
   assign access  = (state == ST_ROW) || (state == ST_MUXED) || (state == ST_COLUMN);
   assign ras_d   = access || (state == ST_REFRESH);               // refresh is ras only
   assign mux_d   = (state == ST_MUXED) || (state == ST_COLUMN);
   assign cas1_d  = (state == ST_COLUMN) && (tgt_q == TGT_RAM_LOWER);
   assign cas2_d  = (state == ST_COLUMN) && (tgt_q == TGT_RAM_UPPER);
   assign boot_d  = access && (tgt_q == TGT_BOOT_ROM);
   assign aux_d   = access && (tgt_q == TGT_AUX_ROM);
   assign en245_d = access && (tgt_q == TGT_EN245);

   always_ff @(posedge b_phi) begin
      if (reset) begin
         ras_n         <= 1'b1;                    // everything released
         mux           <= 1'b0;
         cas1_n        <= 1'b1;
         cas2_n        <= 1'b1;
         boot_rom_cs_n <= 1'b1;
         aux_rom_cs_n  <= 1'b1;
         en245_n       <= 1'b1;
      end else begin
         ras_n         <= !ras_d;                  // +1 after start
         mux           <= mux_d;                   // +2 after start
         cas1_n        <= !cas1_d;                 // +3 after start
         cas2_n        <= !cas2_d;
         boot_rom_cs_n <= !boot_d;
         aux_rom_cs_n  <= !aux_d;
         en245_n       <= !en245_d;
      end
   end

endmodule

// ==== logic/mioc_top.sv ====
// memory and i/o controller top level with the map register, decoder and dram sequencer
module mioc_top
   import mioc_pkg::*;
(
   input  logic     b_phi,                         // z80 clock
   input  logic     reset,                         // sync, active high
   input  addr_hi_t ba,                            // ba15..ba13
   input  logic     ba7,                           // address line 7
   input  logic     ba6,                           // address line 6
   input  map_reg_t bd,                            // data lines bd3..bd0
   input  logic     iorq_n,                        // z80 i/o request
   input  logic     bwr_n,                         // buffered write
   input  logic     mreq_n,                        // buffered memory request
   input  logic     rfsh_n,                        // buffered refresh
   output logic     ras_n,                         // row address strobe
   output logic     mux,                           // dram address mux
   output logic     cas1_n,                        // column strobe for lower ram
   output logic     cas2_n,                        // column strobe for upper ram
   output logic     boot_rom_cs_n,                 // boot rom select
   output logic     aux_rom_cs_n,                  // expansion rom select
   output logic     en245_n                        // onboard 245 enable
);

   map_reg_t map;                                  // memory map from the i/o port
   target_e  target;                               // decoded target of ba

   io_map_register io_map_register_inst (
      .b_phi  (b_phi),
      .reset  (reset),
      .ba7    (ba7),
      .ba6    (ba6),
      .bd     (bd),
      .iorq_n (iorq_n),
      .bwr_n  (bwr_n),
      .map    (map)
   );

   memory_decoder memory_decoder_inst (
      .ba     (ba),
      .map    (map),
      .target (target)
   );

   dram_sequencer dram_sequencer_inst (
      .b_phi         (b_phi),
      .reset         (reset),
      .mreq_n        (mreq_n),
      .rfsh_n        (rfsh_n),
      .target        (target),
      .ras_n         (ras_n),
      .mux           (mux),
      .cas1_n        (cas1_n),
      .cas2_n        (cas2_n),
      .boot_rom_cs_n (boot_rom_cs_n),
      .aux_rom_cs_n  (aux_rom_cs_n),
      .en245_n       (en245_n)
   );

endmodule

// ==== tb/mioc_assertions.sv ====
// dram strobe and chip select protocol properties and their bind to dram_sequencer
module mioc_assertions
   import mioc_pkg::*;
(
   input logic        b_phi,
   input logic        reset,
   input dram_state_e state,                          // sequencer state
   input logic        ras_n,
   input logic        mux,
   input logic        cas1_n,
   input logic        cas2_n,
   input logic        boot_rom_cs_n,
   input logic        aux_rom_cs_n,
   input logic        en245_n
);

   logic [2:0] cs_active;                             // selects, active high

   assign cs_active = {!boot_rom_cs_n, !aux_rom_cs_n, !en245_n};

   cas_needs_ras: assert property (@(posedge b_phi) disable iff (reset)
      (!cas1_n || !cas2_n) |-> !ras_n)
      else $error("column strobe low while ras_n is high");

   one_cas: assert property (@(posedge b_phi) disable iff (reset) cas1_n || cas2_n)
      else $error("cas1_n and cas2_n low together");

   mux_in_row: assert property (@(posedge b_phi) disable iff (reset) mux |-> !ras_n)
      else $error("mux high while ras_n is high");

   one_select: assert property (@(posedge b_phi) disable iff (reset) $countones(cs_active) <= 1)
      else $error("more than one chip select low");

   // outputs lag the state by one edge
   refresh_ras_only: assert property (@(posedge b_phi) disable iff (reset)
      state == ST_REFRESH |=> (!mux && cas1_n && cas2_n && cs_active == 3'b000))
      else $error("refresh drove a strobe other than ras_n");

endmodule

bind dram_sequencer mioc_assertions mioc_assertions_inst (
   .b_phi(b_phi), .reset(reset), .state(state), .ras_n(ras_n), .mux(mux),
   .cas1_n(cas1_n), .cas2_n(cas2_n), .boot_rom_cs_n(boot_rom_cs_n),
   .aux_rom_cs_n(aux_rom_cs_n), .en245_n(en245_n)
);

// ==== tb/tb_mioc.sv ====
// clock, reset, file-driven i/o writes, accesses and refreshes, pin checks and watchdog
module tb_mioc
   import mioc_pkg::*;
;

   localparam int CLK_PERIOD      = 40;
   localparam int RST_CYCLES      = 4;
   localparam int CYCLES_PER_LINE = 12;                // budget per input line for the watchdog
   localparam logic [6:0] IDLE_PINS = 7'b1011111;     // ras_n high, mux low, all selects high

   // target codes as written in the input file
   localparam int EXP_BOOT      = 1;
   localparam int EXP_RAM_LOWER = 2;
   localparam int EXP_RAM_UPPER = 3;
   localparam int EXP_AUX       = 4;
   localparam int EXP_EN245     = 5;

   logic     b_phi;
   logic     reset;
   addr_hi_t ba;
   logic     ba7;
   logic     ba6;
   map_reg_t bd;
   logic     iorq_n;
   logic     bwr_n;
   logic     mreq_n;
   logic     rfsh_n;
   logic     ras_n;
   logic     mux;
   logic     cas1_n;
   logic     cas2_n;
   logic     boot_rom_cs_n;
   logic     aux_rom_cs_n;
   logic     en245_n;
   logic [6:0] pins;                                  // all outputs in one word

   int seed = 52493;                                  // fixed seed for hold lengths
   int errors = 0;
   int checks = 0;
   int tests = 0;
   int n_lines = 0;                                   // lines in the input file

   assign pins = {ras_n, mux, cas1_n, cas2_n, boot_rom_cs_n, aux_rom_cs_n, en245_n};

   always #(CLK_PERIOD / 2) b_phi = ~b_phi;

   mioc_top mioc_top_inst (
      .b_phi(b_phi), .reset(reset), .ba(ba), .ba7(ba7), .ba6(ba6), .bd(bd),
      .iorq_n(iorq_n), .bwr_n(bwr_n), .mreq_n(mreq_n), .rfsh_n(rfsh_n),
      .ras_n(ras_n), .mux(mux), .cas1_n(cas1_n), .cas2_n(cas2_n),
      .boot_rom_cs_n(boot_rom_cs_n), .aux_rom_cs_n(aux_rom_cs_n), .en245_n(en245_n)
   );

   task automatic compare(input logic [6:0] got, input logic [6:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   // expected pins k cycles after the first low sample of mreq_n when it stays low for len edges
   function automatic logic [6:0] expected_pins(input int k, input int len, input int tgt,
                                                input logic refresh);
      logic ras;
      logic col;
      logic mx;
      ras = (k >= 1) && (k <= len);                   // row strobe from +1 to release
      mx  = !refresh && (k >= 2) && (k <= len);       // address switched at +2
      col = !refresh && (k >= 3) && (k <= len);       // column strobe at +3
      return {!ras, mx,
              !(col && tgt == EXP_RAM_LOWER), !(col && tgt == EXP_RAM_UPPER),
              !(!refresh && ras && tgt == EXP_BOOT),
              !(!refresh && ras && tgt == EXP_AUX),
              !(!refresh && ras && tgt == EXP_EN245)};
   endfunction

   task automatic memory_cycle(input addr_hi_t a, input int len, input int tgt,
                               input logic refresh);
      int k;
      @(negedge b_phi);
      ba     = a;
      rfsh_n = !refresh;
      mreq_n = 1'b0;
      for (k = 0; k <= len + 1; k++) begin
         @(negedge b_phi);                            // after rising edge k
         compare(pins, expected_pins(k, len, tgt, refresh), $sformatf("cycle +%0d", k));
         if (k == len - 1) begin
            mreq_n = 1'b1;                            // next edge ends the access
            rfsh_n = 1'b1;
         end
      end
   endtask

   task automatic io_write(input logic a7, input logic a6, input logic wr_n, input map_reg_t nib);
      @(negedge b_phi);
      ba7    = a7;
      ba6    = a6;
      bd     = nib;
      bwr_n  = wr_n;
      iorq_n = 1'b0;
      @(negedge b_phi);
      iorq_n = 1'b1;
      bwr_n  = 1'b1;
      compare(pins, IDLE_PINS, "strobes during i/o write");
   endtask

   initial begin
      int fd;
      int n;
      int err_before;
      int len;
      string line;
      logic [7:0] op;
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
      logic [31:0] f4;
      b_phi  = 1'b0;
      reset  = 1'b1;
      ba     = '0;
      ba7    = 1'b0;
      ba6    = 1'b0;
      bd     = '0;
      iorq_n = 1'b1;
      bwr_n  = 1'b1;
      mreq_n = 1'b1;
      rfsh_n = 1'b1;
      repeat (RST_CYCLES) @(negedge b_phi);
      reset = 1'b0;
      @(negedge b_phi);
      compare(pins, IDLE_PINS, "outputs after reset");
      fd = $fopen("tb/mioc_input.txt", "r");
      if (fd == 0) begin
         $display("could not open the input file tb/mioc_input.txt");
         $display("TEST FAIL");
         $finish;
      end else begin
         while (!$feof(fd)) begin                     // first pass only counts lines
            if ($fgets(line, fd) > 0) begin
               n_lines++;
            end
         end
         $fclose(fd);
         fd = $fopen("tb/mioc_input.txt", "r");
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.substr(0, 0) != "#") begin
               n = $sscanf(line, "%c %h %h %h %h", op, f1, f2, f3, f4);
               if (n == 5) begin
                  err_before = errors;
                  tests++;
                  len = f2;
                  case (op)
                     "w": io_write(f1[0], f2[0], f3[0], f4[3:0]);
                     "m": begin
                        len = f2 + $unsigned($random(seed)) % 4;   // 0 to 3 extra hold
                        memory_cycle(f1[2:0], len, f3, 1'b0);
                     end
                     "r": begin
                        len = f2 + $unsigned($random(seed)) % 4;
                        memory_cycle(f1[2:0], len, 0, 1'b1);
                     end
                     "e": memory_cycle(f1[2:0], len, f3, 1'b0);    // released in row or muxed
                     default: begin
                        errors++;
                        $display("unknown operation '%c' in the input file", op);
                     end
                  endcase
                  $display("test %0d op %c f1=%0h len=%0d: %s", tests, op, f1, len,
                           (errors == err_before) ? "ok" : "failed");
               end
            end
         end
         $fclose(fd);
         if (tests == 0) begin
            errors++;
            $display("no operations were read from the input file");
         end
         $display("done %0d tests, %0d checks, %0d errors", tests, checks, errors);
         if (errors == 0) begin
            $display("TEST PASS");
         end else begin
            $display("TEST FAIL");
         end
         $finish;
      end
   end

   initial begin
      wait (n_lines > 0);                             // starts once the file is counted
      #(n_lines * CYCLES_PER_LINE * CLK_PERIOD);
      $display("watchdog timeout, the run did not end within %0d input lines of time", n_lines);
      $display("TEST FAIL");
      $finish;
   end

endmodule

// ==== tb/mioc_input.txt ====
# op f1 f2 f3 f4 in hex, op w = i/o write (ba7 ba6 bwr_n bd), m = access (ba len target 0)
# r = refresh (0 len 0 0), e = early release (ba len target 0), target 0 none 1 boot 2 ram lo 3 ram up 4 aux 5 en245
m 0 3 1 0   # boot rom at 0000 after reset
m 1 3 0 0   # boot code outside the first 8k
m 4 3 3 0   # upper ram
r 0 3 0 0
w 1 0 0 5   # lower ram, upper aux
m 0 3 2 0
m 3 4 2 0
m 5 3 4 0
w 1 1 0 f   # ba6 high misses the map port
m 2 3 2 0
w 1 0 1 f   # bwr_n high is no write
m 7 3 4 0
w 0 0 0 f   # ba7 low misses the map port
m 6 3 4 0
w 1 0 0 b   # lower en245, upper en245
m 0 3 5 0
m 4 3 5 0
w 1 0 0 e   # lower aux, upper none
m 1 3 4 0
m 6 4 0 0
w 1 0 0 1   # ram in both halves
e 2 1 2 0   # released in row
e 6 2 3 0   # released in muxed
m 7 3 3 0
r 0 2 0 0
e 0 1 2 0

// ==== src.f ====
logic/mioc_pkg.sv
logic/io_map_register.sv
logic/memory_decoder.sv
logic/dram_sequencer.sv
logic/mioc_top.sv
tb/mioc_assertions.sv
tb/tb_mioc.sv

// ==== run_sim.sh ====
#!/bin/sh
# build tb_mioc with verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_mioc -o sim_mioc
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_mioc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
   exit 0
fi
echo "pass line not found in $LOG"
exit 1
